//--- hw/seqConfig.svh
// Sequencer widths, instruction memory depth and opcode field positions
`ifndef SEQ_CONFIG_SVH
`define SEQ_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Program counter and timing tag
////////////////////////////////////////////////////////////////////////////

`define SEQ_ADDR_W	8	// Program address bits
`define SEQ_TAG_W	6	// Rolling issue tag, wraps at 64

////////////////////////////////////////////////////////////////////////////
// Instruction store
////////////////////////////////////////////////////////////////////////////

`define SEQ_IMEM_DEPTH	256	// Words in the program memory
`define SEQ_INSTR_W	24	// One instruction word

// Field widths inside a word
`define SEQ_OPC_W	3
`define SEQ_COND_W	2
`define SEQ_OPND_W	8
`define SEQ_SPARE_W	(`SEQ_INSTR_W - `SEQ_OPC_W - 1 - `SEQ_COND_W - 2 * `SEQ_OPND_W)

// Opcode occupies the top bits of the word
`define SEQ_OPC_MSB	(`SEQ_INSTR_W - 1)
`define SEQ_OPC_LSB	(`SEQ_INSTR_W - `SEQ_OPC_W)

`endif

//--- hw/seqPkg.sv
// Sequencer package with address, tag, status, condition, opcode and instruction types
`include "seqConfig.svh"

package seqPkg;

	// Program address and issue tag
	typedef logic [`SEQ_ADDR_W-1:0]	address_t;
	typedef logic [`SEQ_TAG_W-1:0]	tag_t;

	// Status register, bit index is the condition code
	typedef struct packed {
		logic	zero;	// Bit 3, loop register reached zero
		logic	gt;	// Bit 2
		logic	lt;	// Bit 1
		logic	eq;	// Bit 0
	} status_t;

	// Selects one status bit
	typedef logic [`SEQ_COND_W-1:0]	cond_t;

	// Instruction set
	typedef enum logic [`SEQ_OPC_W-1:0] {
		NOP	= 3'd0,
		CMP	= 3'd1,	// Compare a with b, drives valid1
		DEC	= 3'd2,	// Load or decrement loop register, drives valid2
		JMP	= 3'd3,	// Absolute jump to a
		BR	= 3'd4,	// Relative branch by signed a
		HALT	= 3'd5
	} opcode_t;

	// One instruction word, opcode at the top
	typedef struct packed {
		opcode_t			opcode;
		logic				condSel;	// 0 picks valid1, 1 picks valid2
		cond_t				cond;
		logic [`SEQ_OPND_W-1:0]		a;	// Jump target or branch offset
		logic [`SEQ_OPND_W-1:0]		b;
		logic [`SEQ_SPARE_W-1:0]	spare;
	} instr_t;

	// Issued instruction with its timing tag
	typedef struct packed {
		logic		valid;
		instr_t		instr;
		tag_t		tag;
	} issue_t;

	// Evaluation result strobes
	typedef struct packed {
		logic		valid1;	// Compare done
		logic		valid2;	// Decrement done
		tag_t		tag;	// Tag of the evaluating instruction, held
	} condEvent_t;

endpackage

//--- hw/programAddressCtrl.sv
// Program address controller with jump, tagged branch evaluation and condition-wait stall
`timescale 1ns/1ps

module programAddressCtrl (
	input	logic			clock,
	input	logic			reset,
	input	logic			req,		// Advance request from issue
	input	logic			stall,		// External hold level
	input	seqPkg::issue_t		issue,
	input	seqPkg::condEvent_t	condEvent,
	input	seqPkg::status_t	status,
	output	logic			fetch,
	output	seqPkg::address_t	address,
	output	logic			stallReq
);

	seqPkg::instr_t		curInstr;
	logic			reqAll;
	logic			reqEff;
	logic			curAdv;
	logic			isJump;
	logic			isBranch;
	seqPkg::tag_t		evalNextTag;
	logic			condSeen;
	logic			ready;
	logic			taken;
	logic			doJump;
	logic			doAdvance;
	logic			doFetch;
	logic			waitCond;
	seqPkg::address_t	offset;
	seqPkg::address_t	nextAddress;

	logic			rPend;		// Request parked under stall
	logic			rPendAdv;	// Parked request came with an issued instruction
	logic			rFetch;
	logic			rWait;
	logic			rSeen1;
	logic			rSeen2;
	seqPkg::address_t	rAddress;

	////////////////////////////////////////////////////////////////////////////
	// Request path
	////////////////////////////////////////////////////////////////////////////

	// Issue register stays put until the next capture
	assign curInstr		= issue.instr;
	assign reqAll		= req | rPend;
	assign reqEff		= reqAll & ~stall;	// Stall masks the request
	assign curAdv		= issue.valid | (rPend & rPendAdv);	// Else start fetch

	assign isJump		= curInstr.opcode == seqPkg::JMP;
	assign isBranch		= curInstr.opcode == seqPkg::BR;

	// Branch must directly follow its evaluating instruction
	assign evalNextTag	= condEvent.tag + 1'b1;	// Wraps with the tag
	assign condSeen		= curInstr.condSel ? rSeen2 : rSeen1;
	assign ready		= isBranch & (issue.tag == evalNextTag) & condSeen;
	assign taken		= ready & status[curInstr.cond];

	// Update decisions
	assign doJump		= reqEff & curAdv & isJump;
	assign doAdvance	= reqEff & curAdv & ~isJump & (~isBranch | ready);
	assign doFetch		= reqEff & (~curAdv | ~isBranch | ready);
	assign waitCond		= reqEff & curAdv & isBranch & ~ready;	// Hold and ask reissue

	// Signed offset on taken branch, else plus one
	assign offset		= taken ? seqPkg::address_t'($signed(curInstr.a)) :
				  seqPkg::address_t'(1);
	assign nextAddress	= rAddress + offset;

	assign fetch		= rFetch;
	assign address		= rAddress;
	assign stallReq		= rWait;	// Wait retimed by one cycle

	////////////////////////////////////////////////////////////////////////////
	// State
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			rPend		<= 1'b0;
			rPendAdv	<= 1'b0;
			rFetch		<= 1'b0;
			rWait		<= 1'b0;
		end
		else begin
			rPend		<= reqAll & stall;	// Replay once stall drops
			if (reqAll & stall) begin
				rPendAdv	<= curAdv;
			end
			rFetch		<= doFetch;
			rWait		<= waitCond;
		end
	end

	// Latest evaluation replaces both seen flags
	always_ff @(posedge clock) begin
		if (reset) begin
			rSeen1		<= 1'b0;
			rSeen2		<= 1'b0;
		end
		else if (condEvent.valid1 | condEvent.valid2) begin
			rSeen1		<= condEvent.valid1;
			rSeen2		<= condEvent.valid2;
		end
		else if (doAdvance & isBranch) begin	// Branch used it up
			rSeen1		<= 1'b0;
			rSeen2		<= 1'b0;
		end
	end

	// Program counter
	always_ff @(posedge clock) begin
		if (reset) begin
			rAddress	<= '0;
		end
		else if (doJump) begin
			rAddress	<= curInstr.a;
		end
		else if (doAdvance) begin
			rAddress	<= nextAddress;
		end
	end

	// Jump or taken branch never followed at once by another address change
	assert property (@(posedge clock) disable iff (reset)
		(doJump || (doAdvance && taken)) |=> !(doJump || doAdvance));

	// Stall request only while the held instruction is a branch
	assert property (@(posedge clock) disable iff (reset)
		stallReq |-> isBranch);

endmodule

//--- hw/instrMemory.sv
// Instruction memory with registered read on fetch and a program load port
`timescale 1ns/1ps
`include "seqConfig.svh"

module instrMemory #(
	parameter int DEPTH = `SEQ_IMEM_DEPTH	// Program words
) (
	input	logic			clock,
	input	logic			loadEn,
	input	seqPkg::address_t	loadAddr,
	input	seqPkg::instr_t		loadData,
	input	logic			fetch,
	input	seqPkg::address_t	address,
	output	seqPkg::instr_t		rdata
);

	seqPkg::instr_t		mem [DEPTH];
	seqPkg::address_t	portAddr;

	// Single port shared by load and fetch
	assign portAddr	= loadEn ? loadAddr : address;

	// Write wins over read
	always_ff @(posedge clock) begin
		if (loadEn) begin
			mem[portAddr]	<= loadData;
		end
		else if (fetch) begin
			rdata		<= mem[portAddr];	// Valid the cycle after fetch
		end
	end

	// Program load only while the sequencer is not fetching
	assert property (@(posedge clock) !(loadEn && fetch));

endmodule

//--- hw/issueStage.sv
// Issue stage with read tracking FSM, instruction capture, timing tags and advance request
`timescale 1ns/1ps
`include "seqConfig.svh"

module issueStage (
	input	logic			clock,
	input	logic			reset,
	input	logic			run,		// Start level
	input	logic			rdValid,	// Fetch strobe from address ctrl
	input	seqPkg::instr_t		rdata,
	input	logic			stallReq,	// Branch waiting, issue again
	output	seqPkg::issue_t		issue,
	output	logic			req,
	output	logic			halted
);

	typedef enum logic [1:0] {
		IDLE,
		WAIT_READ,
		ISSUE,
		HALTED
	} state_t;

	state_t			state;
	logic			rdValidQ;	// Memory data valid this cycle
	logic			rIsHalt;
	seqPkg::tag_t		tagCnt;
	seqPkg::instr_t		rInstr;
	seqPkg::tag_t		rTag;
	logic			wordIsHalt;

	// Opcode decode straight from the raw word
	assign wordIsHalt	= rdata[`SEQ_OPC_MSB:`SEQ_OPC_LSB] == seqPkg::HALT;

	////////////////////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////////////////////

	assign issue.valid	= state == ISSUE;
	assign issue.instr	= rInstr;
	assign issue.tag	= rTag;

	// Start request from idle, then one per issued non-HALT
	assign req		= ((state == IDLE) & run) | ((state == ISSUE) & ~rIsHalt);
	assign halted		= state == HALTED;

	////////////////////////////////////////////////////////////////////////////
	// Read tracking and issue FSM
	////////////////////////////////////////////////////////////////////////////

	// Memory read takes one cycle after fetch
	always_ff @(posedge clock) begin
		if (reset) begin
			rdValidQ	<= 1'b0;
		end
		else begin
			rdValidQ	<= rdValid;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state		<= IDLE;
			tagCnt		<= '0;
			rIsHalt		<= 1'b0;
		end
		else begin
			case (state)
				IDLE: begin
					if (run) begin
						state	<= WAIT_READ;	// First fetch at address 0
					end
				end
				WAIT_READ: begin
					if (stallReq) begin	// Same BR, same tag
						state	<= ISSUE;
					end
					else if (rdValidQ) begin
						tagCnt	<= tagCnt + 1'b1;
						rIsHalt	<= wordIsHalt;
						state	<= ISSUE;
					end
				end
				ISSUE: begin
					state	<= rIsHalt ? HALTED : WAIT_READ;
				end
				default: begin
					state	<= HALTED;	// Only reset leaves
				end
			endcase
		end
	end

	// Captured word and its tag
	always_ff @(posedge clock) begin
		if (state == WAIT_READ && !stallReq && rdValidQ) begin
			rInstr	<= rdata;
			rTag	<= tagCnt;
		end
	end

endmodule

//--- hw/evalUnit.sv
// Evaluation unit for compare and loop decrement with status register and tagged strobes
`timescale 1ns/1ps
`include "seqConfig.svh"

module evalUnit (
	input	logic			clock,
	input	logic			reset,
	input	seqPkg::issue_t		issue,
	output	seqPkg::status_t	status,
	output	seqPkg::condEvent_t	condEvent
);

	logic				isCmp;
	logic				isDec;
	logic [`SEQ_OPND_W-1:0]		loopReg;
	logic [`SEQ_OPND_W-1:0]		loopNext;
	seqPkg::status_t		rStatus;
	seqPkg::condEvent_t		rEvent;

	// Reissued branches fall through here untouched
	assign isCmp	= issue.valid & (issue.instr.opcode == seqPkg::CMP);
	assign isDec	= issue.valid & (issue.instr.opcode == seqPkg::DEC);

	// Nonzero b loads the count, zero b steps down
	always_comb begin
		if (issue.instr.b != '0) begin
			loopNext	= issue.instr.b;
		end
		else if (loopReg == '0) begin
			loopNext	= '0;	// Saturate at zero
		end
		else begin
			loopNext	= loopReg - 1'b1;
		end
	end

	assign status		= rStatus;
	assign condEvent	= rEvent;

	////////////////////////////////////////////////////////////////////////////
	// Execute
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			rStatus		<= '0;
			loopReg		<= '0;
			rEvent		<= '0;
		end
		else begin
			rEvent.valid1	<= isCmp;	// One-cycle strobes
			rEvent.valid2	<= isDec;
			if (isCmp | isDec) begin
				rEvent.tag	<= issue.tag;	// Held until next evaluation
			end

			// Unsigned compare of a against b
			if (isCmp) begin
				rStatus.eq	<= issue.instr.a == issue.instr.b;
				rStatus.lt	<= issue.instr.a < issue.instr.b;
				rStatus.gt	<= issue.instr.a > issue.instr.b;
			end

			if (isDec) begin
				loopReg		<= loopNext;
				rStatus.zero	<= loopNext == '0;
			end
		end
	end

endmodule

//--- hw/sequencerTop.sv
// Sequencer top level joining address control, instruction memory, issue and evaluation
`timescale 1ns/1ps

module sequencerTop (
	input	logic			clock,
	input	logic			reset,
	input	logic			run,
	input	logic			stall,
	input	logic			loadEn,
	input	seqPkg::address_t	loadAddr,
	input	seqPkg::instr_t		loadData,
	output	logic			fetch,
	output	seqPkg::address_t	address,
	output	logic			stallReq,
	output	logic			halted,
	output	seqPkg::status_t	status
);

	seqPkg::instr_t		rdata;
	seqPkg::issue_t		issue;
	seqPkg::condEvent_t	condEvent;
	logic			req;

	// Program counter and branch decisions
	programAddressCtrl u_pac (
		.clock		(clock),
		.reset		(reset),
		.req		(req),
		.stall		(stall),
		.issue		(issue),
		.condEvent	(condEvent),
		.status		(status),
		.fetch		(fetch),
		.address	(address),
		.stallReq	(stallReq)
	);

	instrMemory u_imem (
		.clock		(clock),
		.loadEn		(loadEn),
		.loadAddr	(loadAddr),
		.loadData	(loadData),
		.fetch		(fetch),
		.address	(address),
		.rdata		(rdata)
	);

	// Fetch strobe doubles as read-valid, delayed inside
	issueStage u_issue (
		.clock		(clock),
		.reset		(reset),
		.run		(run),
		.rdValid	(fetch),
		.rdata		(rdata),
		.stallReq	(stallReq),
		.issue		(issue),
		.req		(req),
		.halted		(halted)
	);

	evalUnit u_eval (
		.clock		(clock),
		.reset		(reset),
		.issue		(issue),
		.status		(status),
		.condEvent	(condEvent)
	);

endmodule

//--- verif/sequencerTests.svh
// Directed sequencer tests with program image, loading, reference interpreter and trace compare

////////////////////////////////////////////////////////////////////////////
// Program image and run control
////////////////////////////////////////////////////////////////////////////

function automatic seqPkg::instr_t makeInstr(input seqPkg::opcode_t op, input logic condSel,
		input seqPkg::cond_t cond, input logic [`SEQ_OPND_W-1:0] a,
		input logic [`SEQ_OPND_W-1:0] b);
	seqPkg::instr_t w;
	w		= '0;
	w.opcode	= op;
	w.condSel	= condSel;
	w.cond		= cond;
	w.a		= a;
	w.b		= b;
	return w;
endfunction

// HALT everywhere, operands carry the address
task automatic clearImage();
	for (int i = 0; i < MEM_WORDS; i++) begin
		progImage[i] = makeInstr(seqPkg::HALT, 1'b0, 2'd0, 8'(i), ~8'(i));
	end
endtask

task automatic applyReset();
	recording	= 1'b0;
	reset		= 1'b1;
	run		= 1'b0;
	stall		= 1'b0;
	loadEn		= 1'b0;
	repeat (8) nextCycle();
	reset		= 1'b0;
endtask

// Whole image through the load port, run held low
task automatic loadProgram();
	for (int i = 0; i < MEM_WORDS; i++) begin
		loadEn		= 1'b1;
		loadAddr	= seqPkg::address_t'(i);
		loadData	= progImage[i];
		nextCycle();
	end
	loadEn		= 1'b0;
endtask

task automatic startRun();
	observed.delete();
	recording	= 1'b1;
	run		= 1'b1;
endtask

task automatic waitForHalt();
	int cycles;
	cycles = 0;
	@(negedge clock);
	while (!halted && cycles < WAIT_LIMIT) begin
		@(negedge clock);
		cycles++;
	end
	if (!halted) begin
		errorCount++;
		$display("ERROR: %s did not reach HALT within %0d cycles", testName, WAIT_LIMIT);
	end
endtask

////////////////////////////////////////////////////////////////////////////
// Reference interpreter and trace compare
////////////////////////////////////////////////////////////////////////////

// Walks progImage by the sequencer rules
task automatic interpretProgram();
	seqPkg::instr_t		w;
	seqPkg::address_t	pc;
	logic [3:0]		st;
	logic [7:0]		loopCnt;
	logic			lastCmp;	// Previous instruction evaluated a compare
	logic			lastDec;
	logic			done;
	int			steps;
	expectedTrace.delete();
	pc	= '0;
	st	= '0;
	loopCnt	= '0;
	lastCmp	= 1'b0;
	lastDec	= 1'b0;
	done	= 1'b0;
	steps	= 0;
	while (!done && steps < STEP_LIMIT) begin
		expectedTrace.push_back(pc);
		w = progImage[pc];
		steps++;
		case (w.opcode)
			seqPkg::CMP: begin
				st[0]	= w.a == w.b;
				st[1]	= w.a < w.b;
				st[2]	= w.a > w.b;
				pc	= pc + 1'b1;
			end
			seqPkg::DEC: begin
				if (w.b != '0) begin
					loopCnt = w.b;
				end
				else if (loopCnt != '0) begin
					loopCnt = loopCnt - 1'b1;
				end
				st[3]	= loopCnt == '0;
				pc	= pc + 1'b1;
			end
			seqPkg::JMP: pc = w.a;
			seqPkg::BR: begin
				if (!(w.condSel ? lastDec : lastCmp)) begin
					errorCount++;
					$display("ERROR: %s has a branch at 0x%0h that never becomes ready",
						testName, pc);
					done = 1'b1;
				end
				else begin
					pc = st[w.cond] ? pc + w.a : pc + 1'b1;	// 8-bit add wraps as signed
				end
			end
			seqPkg::HALT: done = 1'b1;
			default: pc = pc + 1'b1;
		endcase
		lastCmp	= w.opcode == seqPkg::CMP;
		lastDec	= w.opcode == seqPkg::DEC;
	end
	expectedStatus = st;
endtask

task automatic compareTrace();
	interpretProgram();
	checkValue("trace length", observed.size(), expectedTrace.size());
	for (int i = 0; i < expectedTrace.size() && i < observed.size(); i++) begin
		checkValue($sformatf("fetch address %0d", i), observed[i], expectedTrace[i]);
	end
	checkValue("status", status, expectedStatus);
endtask

// Wait for HALT, then fetch must stay quiet
task automatic finishRun();
	waitForHalt();
	repeat (6) begin
		@(negedge clock);
		checkValue("fetch after halt", fetch, 1'b0);
		checkValue("halted", halted, 1'b1);
	end
	recording = 1'b0;
	compareTrace();
endtask

task automatic runImage();
	applyReset();
	loadProgram();
	startRun();
	finishRun();
endtask

task automatic beginTest(input string name);
	testName	= name;
	errorsAtStart	= errorCount;
	testsRun++;
endtask

task automatic endTest();
	if (errorCount == errorsAtStart) begin
		$display("test %0d %s: pass", testsRun, testName);
	end
	else begin
		testsFailed++;
		$display("test %0d %s: fail with %0d errors", testsRun, testName,
			errorCount - errorsAtStart);
	end
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////////////////////

// Seven NOPs then HALT at 7
task automatic nopStraightRun();
	beginTest("nopStraightRun");
	clearImage();
	for (int i = 0; i < 7; i++) begin
		progImage[i] = makeInstr(seqPkg::NOP, 1'b0, 2'd0, 8'h00, 8'h00);
	end
	progImage[7] = makeInstr(seqPkg::HALT, 1'b0, 2'd0, 8'h00, 8'h00);
	applyReset();
	@(negedge clock);
	checkValue("fetch", fetch, 1'b0);	// Reset values
	checkValue("address", address, 8'h00);
	checkValue("stallReq", stallReq, 1'b0);
	checkValue("halted", halted, 1'b0);
	checkValue("status", status, 4'h0);
	nextCycle();
	loadProgram();
	startRun();
	finishRun();
	for (int i = 0; i < observed.size(); i++) begin
		checkValue($sformatf("sequential address %0d", i), observed[i], i);
	end
	endTest();
endtask

task automatic jumpTarget();
	beginTest("jumpTarget");
	clearImage();
	progImage[8'h00] = makeInstr(seqPkg::NOP, 1'b0, 2'd0, 8'h00, 8'h00);
	progImage[8'h01] = makeInstr(seqPkg::JMP, 1'b0, 2'd0, 8'h40, 8'h00);
	progImage[8'h40] = makeInstr(seqPkg::NOP, 1'b0, 2'd0, 8'h00, 8'h00);
	progImage[8'h41] = makeInstr(seqPkg::JMP, 1'b0, 2'd0, 8'h10, 8'h00);
	progImage[8'h10] = makeInstr(seqPkg::HALT, 1'b0, 2'd0, 8'h00, 8'h00);
	runImage();
	if (observed.size() > 2) begin
		checkValue("address after jump", observed[2], 8'h40);
	end
	endTest();
endtask

// CMP then BR with LFSR operands, forward and backward offsets
task automatic compareBranch();
	logic [31:0]		opA;
	logic [31:0]		opB;
	seqPkg::cond_t		cond;
	seqPkg::address_t	brAddr;
	seqPkg::address_t	offset;
	seqPkg::address_t	expNext;
	logic			taken;
	beginTest("compareBranch");
	for (int n = 0; n < 9; n++) begin
		takeBits(8, opA);
		takeBits(8, opB);
		if (n % 4 == 3) begin
			opB = opA;	// Some equal pairs
		end
		cond = seqPkg::cond_t'(n % 3);
		clearImage();
		if (n % 2 == 0) begin
			brAddr	= 8'd1;
			offset	= 8'd3;
			progImage[0] = makeInstr(seqPkg::CMP, 1'b0, 2'd0, opA[7:0], opB[7:0]);
		end
		else begin
			brAddr	= 8'd9;
			offset	= 8'hfb;	// Minus five
			progImage[0] = makeInstr(seqPkg::JMP, 1'b0, 2'd0, 8'd8, 8'h00);
			progImage[8] = makeInstr(seqPkg::CMP, 1'b0, 2'd0, opA[7:0], opB[7:0]);
		end
		progImage[brAddr] = makeInstr(seqPkg::BR, 1'b0, cond, offset, 8'h00);
		runImage();
		// Both landing spots hold HALT
		case (cond)
			2'd0:		taken = opA[7:0] == opB[7:0];
			2'd1:		taken = opA[7:0] < opB[7:0];
			default:	taken = opA[7:0] > opB[7:0];
		endcase
		expNext = taken ? brAddr + offset : brAddr + 1'b1;
		if (observed.size() > 0) begin
			checkValue("address after branch", observed[observed.size() - 1], expNext);
		end
		checkValue("status gt lt eq", {status.gt, status.lt, status.eq},
			{opA[7:0] > opB[7:0], opA[7:0] < opB[7:0], opA[7:0] == opB[7:0]});
	end
	endTest();
endtask

// Body at 1 runs once per loaded count
task automatic decLoop();
	int bodyRuns;
	beginTest("decLoop");
	clearImage();
	progImage[0] = makeInstr(seqPkg::DEC, 1'b0, 2'd0, 8'h00, 8'd5);
	progImage[1] = makeInstr(seqPkg::NOP, 1'b0, 2'd0, 8'h00, 8'h00);
	progImage[2] = makeInstr(seqPkg::DEC, 1'b0, 2'd0, 8'h00, 8'h00);
	progImage[3] = makeInstr(seqPkg::BR, 1'b1, 2'd3, 8'd2, 8'h00);	// Exit on zero
	progImage[4] = makeInstr(seqPkg::JMP, 1'b0, 2'd0, 8'd1, 8'h00);
	progImage[5] = makeInstr(seqPkg::HALT, 1'b0, 2'd0, 8'h00, 8'h00);
	runImage();
	bodyRuns = 0;
	foreach (observed[i]) begin
		if (observed[i] == 8'd1) begin
			bodyRuns++;
		end
	end
	checkValue("loop body count", bodyRuns, 5);
	endTest();
endtask

// External stall mid-run freezes fetch and address
task automatic stallFreeze();
	int			cycles;
	int			heldCount;
	seqPkg::address_t	heldAddr;
	beginTest("stallFreeze");
	clearImage();
	for (int i = 0; i < 10; i++) begin
		progImage[i] = makeInstr(seqPkg::NOP, 1'b0, 2'd0, 8'h00, 8'h00);
	end
	progImage[10] = makeInstr(seqPkg::HALT, 1'b0, 2'd0, 8'h00, 8'h00);
	applyReset();
	loadProgram();
	startRun();
	cycles = 0;
	while (observed.size() < 4 && cycles < WAIT_LIMIT) begin
		nextCycle();
		cycles++;
	end
	if (observed.size() < 4) begin
		errorCount++;
		$display("ERROR: %s saw too few fetches before the stall", testName);
	end
	stall = 1'b1;
	nextCycle();	// Fetch already decided may still show
	nextCycle();
	@(negedge clock);
	heldAddr	= address;
	heldCount	= observed.size();
	repeat (12) begin
		@(negedge clock);
		checkValue("fetch under stall", fetch, 1'b0);
		checkValue("address under stall", address, heldAddr);
	end
	checkValue("fetch count under stall", observed.size(), heldCount);
	nextCycle();
	stall = 1'b0;
	finishRun();
	endTest();
endtask

//--- verif/sequencerTb.sv
// Sequencer testbench with clock, reset, DUT, fetch trace monitor, LFSR, check task and test order
`timescale 1ns/1ps
`include "seqConfig.svh"

module sequencerTb;

	localparam int MEM_WORDS	= `SEQ_IMEM_DEPTH;
	localparam int WAIT_LIMIT	= 3000;	// Cycles allowed per wait loop
	localparam int STEP_LIMIT	= 500;	// Reference interpreter step bound

	logic			clock;
	logic			reset;
	logic			run;
	logic			stall;
	logic			loadEn;
	seqPkg::address_t	loadAddr;
	seqPkg::instr_t		loadData;
	logic			fetch;
	seqPkg::address_t	address;
	logic			stallReq;
	logic			halted;
	seqPkg::status_t	status;

	seqPkg::instr_t		progImage [MEM_WORDS];	// Mirror of the loaded program
	seqPkg::address_t	observed[$];		// Fetch addresses from the DUT
	seqPkg::address_t	expectedTrace[$];	// Fetch addresses from the interpreter
	logic [3:0]		expectedStatus;		// eq lt gt zero from bit 0 up
	logic			recording;
	logic [31:0]		lfsrState;
	int			errorCount;
	int			checkCount;
	int			testsRun;
	int			testsFailed;
	int			errorsAtStart;
	string			testName;

	sequencerTop u_dut (
		.clock		(clock),
		.reset		(reset),
		.run		(run),
		.stall		(stall),
		.loadEn		(loadEn),
		.loadAddr	(loadAddr),
		.loadData	(loadData),
		.fetch		(fetch),
		.address	(address),
		.stallReq	(stallReq),
		.halted		(halted),
		.status		(status)
	);

	always #20 clock = ~clock;	// 40 ns period

	// Every fetch address, sampled at the falling edge
	always @(negedge clock) begin
		if (recording && fetch) begin
			observed.push_back(address);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Random bits and checking
	////////////////////////////////////////////////////////////////////////////

	// 32-bit Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// One LFSR step for each bit taken
	task automatic takeBits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState	= lfsrNext(lfsrState);
			value		= {value[30:0], lfsrState[0]};
		end
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("CHECK FAILED: %s actual 0x%0h expected 0x%0h in %s at %0t",
				name, actual, expected, testName, $time);
		end
	endtask

	// Inputs change just after the rising edge
	task automatic nextCycle();
		@(posedge clock);
		#1;
	endtask

	`include "sequencerTests.svh"

	////////////////////////////////////////////////////////////////////////////
	// Test order
	////////////////////////////////////////////////////////////////////////////

	initial begin
		clock		= 1'b0;
		reset		= 1'b1;
		run		= 1'b0;
		stall		= 1'b0;
		loadEn		= 1'b0;
		loadAddr	= '0;
		loadData	= '0;
		recording	= 1'b0;
		lfsrState	= 32'h7aa7;
		errorCount	= 0;
		checkCount	= 0;
		testsRun	= 0;
		testsFailed	= 0;
		errorsAtStart	= 0;
		testName	= "setup";

		nopStraightRun();
		jumpTarget();
		compareBranch();
		decLoop();
		stallFreeze();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			testsRun, testsFailed, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("SIMULATION PASSED");
		end
		else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- filelist.f
+incdir+hw
+incdir+verif
hw/seqPkg.sv
hw/programAddressCtrl.sv
hw/instrMemory.sv
hw/issueStage.sv
hw/evalUnit.sv
hw/sequencerTop.sv
verif/sequencerTb.sv

//--- Bender.yml
package:
  name: sequencer

sources:
  - include_dirs:
      - hw
    files:
      - hw/seqPkg.sv
      - hw/programAddressCtrl.sv
      - hw/instrMemory.sv
      - hw/issueStage.sv
      - hw/evalUnit.sv
      - hw/sequencerTop.sv
  - target: test
    include_dirs:
      - hw
      - verif
    files:
      - verif/sequencerTb.sv
